/* design/wb_ctrl_fsm.sv */
// Controller FSM for write-back
// Halts write-back on request and kills the op that follows an abort

`timescale 1ns/1ps
`default_nettype none

module wb_ctrl_fsm import wb_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n_i,

  input  logic      halt_req_i,
  input  logic      wb_valid_i,
  input  logic      abort_op_i,

  output ctrl_fsm_t ctrl_fsm_o,
  output logic      halted_o
);

  ctrl_state_e state_q;
  ctrl_state_e state_d;
  logic        aborted;

  // An op finished with an abort this cycle
  assign aborted = wb_valid_i && abort_op_i;

  always_comb begin
    state_d = state_q;
    case (state_q)
      RUN: begin
        // The abort wins, the halt is taken one cycle later
        if (aborted) begin
          state_d = FLUSH;
        end else if (halt_req_i) begin
          state_d = HALTED;
        end
      end
      HALTED: begin
        // An access already under way may still end in a fault
        if (aborted) begin
          state_d = FLUSH;
        end else if (!halt_req_i) begin
          state_d = RUN;
        end
      end
      FLUSH: begin
        state_d = RUN;
      end
      default: begin
        state_d = RUN;
      end
    endcase
  end

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= RUN;
    end else begin
      state_q <= state_d;
    end
  end

  // Commands decode straight from the state
  assign ctrl_fsm_o.halt_wb = (state_q == HALTED);
  assign ctrl_fsm_o.kill_wb = (state_q == FLUSH);
  assign halted_o           = (state_q == HALTED);

endmodule

`default_nettype wire

/* design/wb_ex_pipe.sv */
// EX/WB pipeline register
// Accepts one operation per valid/ready handshake and holds it
// until write-back moves on or the controller kills it

`timescale 1ns/1ps
`default_nettype none

module wb_ex_pipe import wb_pkg::*;
(
  input  logic        clk,
  input  logic        rst_n_i,

  // Issue side
  input  logic        ex_valid_i,
  input  ex_wb_pipe_t ex_op_i,
  output logic        ex_ready_o,

  // Write-back side
  input  logic        wb_ready_i,
  input  ctrl_fsm_t   ctrl_fsm_i,
  output ex_wb_pipe_t ex_wb_pipe_o
);

  logic        valid_q;
  ex_wb_pipe_t payload_q;
  logic        move;

  // The register advances when empty, when write-back is done with its op,
  // or when the controller kills the op that sits in write-back
  assign move       = !valid_q || wb_ready_i || ctrl_fsm_i.kill_wb;
  assign ex_ready_o = move;

  // Only the valid bit is control state
  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      valid_q <= 1'b0;
    end else if (move) begin
      // Cleared when the op leaves with nothing new behind it
      valid_q <= ex_valid_i;
    end
  end

  always_ff @(posedge clk) begin
    if (move && ex_valid_i) begin
      payload_q <= ex_op_i;
    end
  end

  always_comb begin
    ex_wb_pipe_o             = payload_q;
    ex_wb_pipe_o.instr_valid = valid_q;
  end

endmodule

`default_nettype wire

/* design/wb_load_unit.sv */
// Load unit with word-addressed data RAM
// MPU bound check and wait-state timer behind a request/response handshake

`timescale 1ns/1ps
`default_nettype none

module wb_load_unit import wb_pkg::*;
#(
  parameter int LOAD_WAIT = 2,
  parameter int MPU_LIMIT = 192,
  parameter int RAM_WORDS = 256
)
(
  input  logic      clk,
  input  logic      rst_n_i,

  input  logic      lsu_valid_i,
  input  lsu_req_t  lsu_req_i,
  output logic      lsu_ready_o,

  output logic      lsu_resp_valid_o,
  output lsu_resp_t lsu_resp_o
);

  // Timer is at least one bit wide, also for zero wait states
  localparam int CNT_W = (LOAD_WAIT > 0) ? $clog2(LOAD_WAIT + 1) : 1;

  word_t            mem [RAM_WORDS];
  logic             busy_q;
  logic [CNT_W-1:0] cnt_q;
  lsu_req_t         req_q;
  logic             accept;
  logic             resp_fire;
  logic             mpu_err;

  assign lsu_ready_o = !busy_q;
  assign accept      = lsu_valid_i && !busy_q;

  // Response goes out once the timer has run down
  assign resp_fire   = busy_q && (cnt_q == '0);

  // Addresses at or above the bound fault
  assign mpu_err     = (int'(req_q.addr) >= MPU_LIMIT);

  ////////////////////////////////////////////////////////////////////
  // Wait-state timer
  ////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      busy_q <= 1'b0;
      cnt_q  <= '0;
    end else if (accept) begin
      busy_q <= 1'b1;
      cnt_q  <= CNT_W'(LOAD_WAIT);
    end else if (resp_fire) begin
      busy_q <= 1'b0;
    end else if (busy_q) begin
      cnt_q  <= cnt_q - 1'b1;
    end
  end

  // Request is captured on acceptance and held for the whole access
  always_ff @(posedge clk) begin
    if (accept) begin
      req_q <= lsu_req_i;
    end
  end

  ////////////////////////////////////////////////////////////////////
  // Data RAM
  ////////////////////////////////////////////////////////////////////

  // A store writes on the cycle its response goes out, unless it faults
  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      for (int i = 0; i < RAM_WORDS; i++) begin
        mem[i] <= '0;
      end
    end else if (resp_fire && req_q.we && !mpu_err) begin
      mem[req_q.addr] <= req_q.wdata;
    end
  end

  // Read data is meaningless for a store
  assign lsu_resp_valid_o   = resp_fire;
  assign lsu_resp_o.rdata   = mem[req_q.addr];
  assign lsu_resp_o.mpu_err = mpu_err;

endmodule

`default_nettype wire

/* design/wb_pkg.sv */
// Shared definitions for the write-back subsystem
// Widths, operation and FSM encodings, and the packed structs that
// travel between issue, write-back, the load unit and the controller

`default_nettype none

package wb_pkg;

  ////////////////////////////////////////////////////////////////////
  // Widths with a meaning
  ////////////////////////////////////////////////////////////////////

  typedef logic [31:0] word_t;
  typedef logic [4:0]  rf_addr_t;
  // Word address into the data RAM
  typedef logic [7:0]  mem_addr_t;

  // Kind of operation handed over from execute
  typedef enum logic [1:0] {
    ALU   = 2'd0,
    LOAD  = 2'd1,
    STORE = 2'd2,
    XIF   = 2'd3
  } op_kind_e;

  // Controller states
  typedef enum logic [1:0] {
    RUN    = 2'd0,
    HALTED = 2'd1,
    FLUSH  = 2'd2
  } ctrl_state_e;

  ////////////////////////////////////////////////////////////////////
  // Structs
  ////////////////////////////////////////////////////////////////////

  // EX/WB pipeline contents, rf_wdata is the execute result or store data
  typedef struct packed {
    logic      instr_valid;
    op_kind_e  op_kind;
    logic      rf_we;
    rf_addr_t  rf_waddr;
    word_t     rf_wdata;
    mem_addr_t mem_addr;
    logic      last_op;
  } ex_wb_pipe_t;

  // Coprocessor result, exc inhibits write-back
  typedef struct packed {
    word_t data;
    logic  exc;
  } xif_result_t;

  // Controller commands to write-back
  typedef struct packed {
    logic halt_wb;
    logic kill_wb;
  } ctrl_fsm_t;

  typedef struct packed {
    logic      we;
    mem_addr_t addr;
    word_t     wdata;
  } lsu_req_t;

  typedef struct packed {
    word_t rdata;
    logic  mpu_err;
  } lsu_resp_t;

endpackage

`default_nettype wire

/* design/wb_regfile.sv */
// Register file with thirty-two entries
// One write port, one combinational read port, register zero reads as zero

`timescale 1ns/1ps
`default_nettype none

module wb_regfile import wb_pkg::*;
(
  input  logic     clk,
  input  logic     rst_n_i,

  input  logic     we_i,
  input  rf_addr_t waddr_i,
  input  word_t    wdata_i,

  input  rf_addr_t raddr_i,
  output word_t    rdata_o
);

  word_t regs [32];

  // Entry zero is cleared by reset and never written afterwards
  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (we_i && (waddr_i != '0)) begin
      regs[waddr_i] <= wdata_i;
    end
  end

  assign rdata_o = regs[raddr_i];

endmodule

`default_nettype wire

/* design/wb_stage.sv */
// Write-back stage
// Selects write data, gates the register file write, issues load unit
// requests and forms the stage ready/valid and abort signals

`timescale 1ns/1ps
`default_nettype none

module wb_stage import wb_pkg::*;
(
  input  logic        clk,
  input  logic        rst_n_i,

  input  ex_wb_pipe_t ex_wb_pipe_i,
  input  ctrl_fsm_t   ctrl_fsm_i,

  // Load unit
  output logic        lsu_valid_o,
  output lsu_req_t    lsu_req_o,
  input  logic        lsu_ready_i,
  input  logic        lsu_resp_valid_i,
  input  lsu_resp_t   lsu_resp_i,

  // Coprocessor result
  input  logic        xif_result_valid_i,
  input  xif_result_t xif_result_i,
  output logic        xif_result_ready_o,

  // Register file
  output logic        rf_we_o,
  output rf_addr_t    rf_waddr_o,
  output word_t       rf_wdata_o,

  output logic        wb_ready_o,
  output logic        wb_valid_o,
  output logic        abort_op_o,
  output logic        data_stall_o,
  output logic        last_op_o
);

  logic lsu_sent_q;
  logic is_load;
  logic is_store;
  logic is_mem;
  logic is_xif;
  logic halt_blk;
  logic instr_valid;
  logic lsu_wait;
  logic xif_wait;
  logic lsu_exception;
  logic xif_exception;
  logic done;

  assign is_load  = (ex_wb_pipe_i.op_kind == LOAD);
  assign is_store = (ex_wb_pipe_i.op_kind == STORE);
  assign is_mem   = is_load || is_store;
  assign is_xif   = (ex_wb_pipe_i.op_kind == XIF);

  // Halt only holds an op that has not yet started its memory access,
  // an access already under way is allowed to finish
  assign halt_blk    = ctrl_fsm_i.halt_wb && !lsu_sent_q;
  assign instr_valid = ex_wb_pipe_i.instr_valid && !ctrl_fsm_i.kill_wb && !halt_blk;

  ////////////////////////////////////////////////////////////////////
  // Load unit handshake
  ////////////////////////////////////////////////////////////////////

  // One request per op, raised in its first cycle in write-back
  assign lsu_valid_o     = instr_valid && is_mem && !lsu_sent_q;
  assign lsu_req_o.we    = is_store;
  assign lsu_req_o.addr  = ex_wb_pipe_i.mem_addr;
  assign lsu_req_o.wdata = ex_wb_pipe_i.rf_wdata;

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      lsu_sent_q <= 1'b0;
    end else if (lsu_resp_valid_i) begin
      lsu_sent_q <= 1'b0;
    end else if (lsu_valid_o && lsu_ready_i) begin
      lsu_sent_q <= 1'b1;
    end
  end

  ////////////////////////////////////////////////////////////////////
  // Completion and exceptions
  ////////////////////////////////////////////////////////////////////

  assign lsu_wait      = ex_wb_pipe_i.instr_valid && is_mem && !lsu_resp_valid_i;
  assign xif_wait      = ex_wb_pipe_i.instr_valid && is_xif && !xif_result_valid_i;
  assign lsu_exception = instr_valid && is_mem && lsu_resp_valid_i && lsu_resp_i.mpu_err;
  assign xif_exception = instr_valid && is_xif && xif_result_valid_i && xif_result_i.exc;

  // Result is present for ALU ops right away, otherwise once the answer is in
  assign done = is_mem ? lsu_resp_valid_i :
                is_xif ? xif_result_valid_i : 1'b1;

  // Always accept a response, there is no stage downstream
  assign xif_result_ready_o = instr_valid && is_xif;

  // A kill lets the stage drop its op at once
  assign wb_ready_o   = ctrl_fsm_i.kill_wb || (!halt_blk && !lsu_wait && !xif_wait);
  assign wb_valid_o   = instr_valid && done;
  assign abort_op_o   = lsu_exception || xif_exception;
  assign data_stall_o = instr_valid && is_mem && !lsu_resp_valid_i;
  assign last_op_o    = ex_wb_pipe_i.last_op;

  ////////////////////////////////////////////////////////////////////
  // Register file write
  ////////////////////////////////////////////////////////////////////

  // Stores never write, faults and coprocessor exceptions suppress the write
  assign rf_we_o    = instr_valid && ex_wb_pipe_i.rf_we && !is_store && done &&
                      !lsu_exception && !xif_exception;
  assign rf_waddr_o = ex_wb_pipe_i.rf_waddr;
  assign rf_wdata_o = is_load ? lsu_resp_i.rdata :
                      is_xif  ? xif_result_i.data : ex_wb_pipe_i.rf_wdata;

endmodule

`default_nettype wire

/* design/wb_subsystem_top.sv */
// Top level of the write-back subsystem
// Connects issue register, write-back stage, load unit, register file
// and controller FSM, and sets the load unit parameters

`timescale 1ns/1ps
`default_nettype none

module wb_subsystem_top import wb_pkg::*;
#(
  parameter int LOAD_WAIT = 2,
  parameter int MPU_LIMIT = 192,
  parameter int RAM_WORDS = 256
)
(
  input  logic        clk,
  input  logic        rst_n_i,

  // Issue port
  input  logic        ex_valid_i,
  input  ex_wb_pipe_t ex_op_i,
  output logic        ex_ready_o,

  // Coprocessor result port
  input  logic        xif_result_valid_i,
  input  xif_result_t xif_result_i,
  output logic        xif_result_ready_o,

  input  logic        halt_req_i,
  input  rf_addr_t    rf_raddr_i,
  output word_t       rf_rdata_o,

  output logic        wb_valid_o,
  output logic        abort_op_o,
  output logic        data_stall_o,
  output logic        halted_o
);

  ex_wb_pipe_t ex_wb_pipe;
  ctrl_fsm_t   ctrl_fsm;
  logic        wb_ready;
  logic        lsu_valid;
  logic        lsu_ready;
  lsu_req_t    lsu_req;
  logic        lsu_resp_valid;
  lsu_resp_t   lsu_resp;
  logic        rf_we;
  rf_addr_t    rf_waddr;
  word_t       rf_wdata;

  ////////////////////////////////////////////////////////////////////
  // Pipeline and write-back
  ////////////////////////////////////////////////////////////////////

  wb_ex_pipe u_ex_pipe (
    .clk          (clk),
    .rst_n_i      (rst_n_i),
    .ex_valid_i   (ex_valid_i),
    .ex_op_i      (ex_op_i),
    .ex_ready_o   (ex_ready_o),
    .wb_ready_i   (wb_ready),
    .ctrl_fsm_i   (ctrl_fsm),
    .ex_wb_pipe_o (ex_wb_pipe)
  );

  // The last_op flag has no user at this level
  wb_stage u_wb_stage (
    .clk                (clk),
    .rst_n_i            (rst_n_i),
    .ex_wb_pipe_i       (ex_wb_pipe),
    .ctrl_fsm_i         (ctrl_fsm),
    .lsu_valid_o        (lsu_valid),
    .lsu_req_o          (lsu_req),
    .lsu_ready_i        (lsu_ready),
    .lsu_resp_valid_i   (lsu_resp_valid),
    .lsu_resp_i         (lsu_resp),
    .xif_result_valid_i (xif_result_valid_i),
    .xif_result_i       (xif_result_i),
    .xif_result_ready_o (xif_result_ready_o),
    .rf_we_o            (rf_we),
    .rf_waddr_o         (rf_waddr),
    .rf_wdata_o         (rf_wdata),
    .wb_ready_o         (wb_ready),
    .wb_valid_o         (wb_valid_o),
    .abort_op_o         (abort_op_o),
    .data_stall_o       (data_stall_o),
    .last_op_o          ()
  );

  ////////////////////////////////////////////////////////////////////
  // Data side, storage and control
  ////////////////////////////////////////////////////////////////////

  wb_load_unit #(
    .LOAD_WAIT (LOAD_WAIT),
    .MPU_LIMIT (MPU_LIMIT),
    .RAM_WORDS (RAM_WORDS)
  ) u_load_unit (
    .clk              (clk),
    .rst_n_i          (rst_n_i),
    .lsu_valid_i      (lsu_valid),
    .lsu_req_i        (lsu_req),
    .lsu_ready_o      (lsu_ready),
    .lsu_resp_valid_o (lsu_resp_valid),
    .lsu_resp_o       (lsu_resp)
  );

  wb_regfile u_regfile (
    .clk     (clk),
    .rst_n_i (rst_n_i),
    .we_i    (rf_we),
    .waddr_i (rf_waddr),
    .wdata_i (rf_wdata),
    .raddr_i (rf_raddr_i),
    .rdata_o (rf_rdata_o)
  );

  wb_ctrl_fsm u_ctrl_fsm (
    .clk        (clk),
    .rst_n_i    (rst_n_i),
    .halt_req_i (halt_req_i),
    .wb_valid_i (wb_valid_o),
    .abort_op_i (abort_op_o),
    .ctrl_fsm_o (ctrl_fsm),
    .halted_o   (halted_o)
  );

endmodule

`default_nettype wire

/* run.sh */
#!/bin/sh
# Build and run the write-back subsystem testbench with Verilator
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert --top-module wb_tb -f tb.f -o wb_sim; then
  echo "Build failed"
  exit 1
fi

out=$(./obj_dir/wb_sim)
status=$?
printf '%s\n' "$out"
if [ "$status" -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$out" | grep -qF '*** PASSED ***'; then
  exit 0
fi
exit 1

/* tb.f */
design/wb_pkg.sv
design/wb_ex_pipe.sv
design/wb_load_unit.sv
design/wb_stage.sv
design/wb_regfile.sv
design/wb_ctrl_fsm.sv
design/wb_subsystem_top.sv
verif/wb_properties.sv
verif/wb_tb.sv

/* verif/wb_properties.sv */
// Concurrent assertions bound to the write-back stage
// Register write gating after an abort, load unit request stability and
// load unit responses only for memory operations

`timescale 1ns/1ps
`default_nettype none

module wb_properties import wb_pkg::*;
(
  input logic        clk,
  input logic        rst_n_i,
  input ex_wb_pipe_t ex_wb_pipe_i,
  input logic        lsu_valid_o,
  input lsu_req_t    lsu_req_o,
  input logic        lsu_ready_i,
  input logic        lsu_resp_valid_i,
  input logic        rf_we_o,
  input logic        abort_op_o
);

  // The op behind an aborted one is killed and never reaches the register file
  a_no_write_after_abort: assert property (
    @(posedge clk) disable iff (!rst_n_i) abort_op_o |=> !rf_we_o
  ) else $error("register write in the cycle after an abort");

  // A request that is not accepted stays up and unchanged
  a_req_stable: assert property (
    @(posedge clk) disable iff (!rst_n_i)
    (lsu_valid_o && !lsu_ready_i) |=> (lsu_valid_o && $stable(lsu_req_o))
  ) else $error("load unit request changed while waiting for ready");

  // A response only ever lands on a memory op, so no other op raised a request
  a_resp_for_mem_op: assert property (
    @(posedge clk) disable iff (!rst_n_i)
    lsu_resp_valid_i |-> (ex_wb_pipe_i.instr_valid &&
                          (ex_wb_pipe_i.op_kind == LOAD || ex_wb_pipe_i.op_kind == STORE))
  ) else $error("load unit response while no memory op is in write-back");

endmodule

bind wb_stage wb_properties u_properties (
  .clk              (clk),
  .rst_n_i          (rst_n_i),
  .ex_wb_pipe_i     (ex_wb_pipe_i),
  .lsu_valid_o      (lsu_valid_o),
  .lsu_req_o        (lsu_req_o),
  .lsu_ready_i      (lsu_ready_i),
  .lsu_resp_valid_i (lsu_resp_valid_i),
  .rf_we_o          (rf_we_o),
  .abort_op_o       (abort_op_o)
);

`default_nettype wire

/* verif/wb_tb.sv */
// Trace-driven testbench for the write-back subsystem
// Clock and reset, issue driver, coprocessor responder, halt driver,
// reference model of register file and RAM, and the compare task

`timescale 1ns/1ps
`default_nettype none

module wb_tb import wb_pkg::*;;

  localparam int LOAD_WAIT      = 2;
  localparam int MPU_LIMIT      = 192;
  localparam int RAM_WORDS      = 256;
  localparam int TIMEOUT_CYCLES = 200;

  logic        clk;
  logic        rst_n_i;
  logic        ex_valid_i;
  ex_wb_pipe_t ex_op_i;
  logic        ex_ready_o;
  logic        xif_result_valid_i;
  xif_result_t xif_result_i;
  logic        xif_result_ready_o;
  logic        halt_req_i;
  rf_addr_t    rf_raddr_i;
  word_t       rf_rdata_o;
  logic        wb_valid_o;
  logic        abort_op_o;
  logic        data_stall_o;
  logic        halted_o;

  // Reference model state
  word_t exp_rf [32];
  word_t exp_mem [RAM_WORDS];
  logic  discard_next;
  int    exp_done;
  int    exp_abort;

  // Pending coprocessor answer, armed by an X line
  logic  xif_armed;
  int    xif_delay;
  word_t xif_data;
  logic  xif_exc;

  int       halt_cycles;
  logic     stall_seen;
  int       done_cnt;
  int       abort_cnt;
  // Kind of the op that last entered write-back
  op_kind_e last_kind;

  wb_subsystem_top #(
    .LOAD_WAIT (LOAD_WAIT),
    .MPU_LIMIT (MPU_LIMIT),
    .RAM_WORDS (RAM_WORDS)
  ) dut (
    .clk                (clk),
    .rst_n_i            (rst_n_i),
    .ex_valid_i         (ex_valid_i),
    .ex_op_i            (ex_op_i),
    .ex_ready_o         (ex_ready_o),
    .xif_result_valid_i (xif_result_valid_i),
    .xif_result_i       (xif_result_i),
    .xif_result_ready_o (xif_result_ready_o),
    .halt_req_i         (halt_req_i),
    .rf_raddr_i         (rf_raddr_i),
    .rf_rdata_o         (rf_rdata_o),
    .wb_valid_o         (wb_valid_o),
    .abort_op_o         (abort_op_o),
    .data_stall_o       (data_stall_o),
    .halted_o           (halted_o)
  );

  always #2 clk = ~clk;

  ////////////////////////////////////////////////////////////////////
  // Reporting
  ////////////////////////////////////////////////////////////////////

  task automatic end_in_failure();
    $display("*** FAILED ***");
    $fatal(1, "simulation stopped on error");
  endtask

  task automatic report_timeout(input string what);
    $display("Timeout: %s", what);
    end_in_failure();
  endtask

  task automatic check_value(input word_t actual, input word_t expected, input string what);
    if (actual !== expected) begin
      $display("Fail at %0t ns: %s, got %h, expected %h", $time, what, actual, expected);
      end_in_failure();
    end
  endtask

  ////////////////////////////////////////////////////////////////////
  // Drivers
  ////////////////////////////////////////////////////////////////////

  // Presents an op on the falling edge and returns after the transfer edge
  task automatic issue_op(input ex_wb_pipe_t op);
    int waited;
    waited = 0;
    @(negedge clk);
    ex_op_i    = op;
    ex_valid_i = 1'b1;
    #1;
    while (!ex_ready_o) begin
      @(negedge clk);
      #1;
      waited++;
      if (waited > TIMEOUT_CYCLES) begin
        report_timeout("ex_ready_o never rose for an issued op");
      end
    end
    @(posedge clk);
    last_kind = op.op_kind;
  endtask

  // Waits until write-back holds no op
  task automatic wait_idle();
    int waited;
    waited = 0;
    @(negedge clk);
    ex_valid_i = 1'b0;
    #1;
    while (dut.ex_wb_pipe.instr_valid) begin
      @(negedge clk);
      #1;
      waited++;
      if (waited > TIMEOUT_CYCLES) begin
        report_timeout("write-back never drained");
      end
    end
  endtask

  // Coprocessor responder, answers one armed XIF op
  initial begin
    int waited;
    forever begin
      wait (xif_armed);
      waited = 0;
      @(negedge clk);
      #1;
      while (!xif_result_ready_o) begin
        @(negedge clk);
        #1;
        waited++;
        if (waited > TIMEOUT_CYCLES) begin
          report_timeout("xif_result_ready_o never rose");
        end
      end
      repeat (xif_delay + 1) @(negedge clk);
      xif_result_i.data  = xif_data;
      xif_result_i.exc   = xif_exc;
      xif_result_valid_i = 1'b1;
      @(negedge clk);
      xif_result_valid_i = 1'b0;
      xif_armed          = 1'b0;
    end
  end

  // Halt driver, nothing may be written and issue stays blocked while halted
  initial begin
    int waited;
    forever begin
      wait (halt_cycles != 0);
      waited = 0;
      @(negedge clk);
      halt_req_i = 1'b1;
      #1;
      while (!halted_o) begin
        @(negedge clk);
        #1;
        waited++;
        if (waited > TIMEOUT_CYCLES) begin
          report_timeout("halted_o never rose");
        end
      end
      for (int i = 0; i < halt_cycles; i++) begin
        @(negedge clk);
        #1;
        check_value(32'(ex_ready_o), 32'd0, "ex_ready_o while halted");
        check_value(32'(dut.rf_we), 32'd0, "register write while halted");
      end
      @(negedge clk);
      halt_req_i  = 1'b0;
      halt_cycles = 0;
    end
  end

  // Counts completions and aborts and notes a stall while a load sits in write-back
  always begin
    @(negedge clk);
    #1;
    if (wb_valid_o) done_cnt++;
    if (abort_op_o) abort_cnt++;
    if (data_stall_o && (last_kind == LOAD)) stall_seen = 1'b1;
  end

  ////////////////////////////////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////////////////////////////////

  // The op accepted right after an aborted one is killed
  task automatic model_op(input ex_wb_pipe_t op);
    logic write_ok;
    write_ok = op.rf_we && (op.rf_waddr != 5'd0);
    if (discard_next) begin
      discard_next = 1'b0;
    end else begin
      exp_done++;
      case (op.op_kind)
        ALU: if (write_ok) exp_rf[op.rf_waddr] = op.rf_wdata;
        LOAD: begin
          if (int'(op.mem_addr) >= MPU_LIMIT) discard_next = 1'b1;
          else if (write_ok) exp_rf[op.rf_waddr] = exp_mem[op.mem_addr];
        end
        STORE: begin
          if (int'(op.mem_addr) >= MPU_LIMIT) discard_next = 1'b1;
          else exp_mem[op.mem_addr] = op.rf_wdata;
        end
        default: begin
          if (xif_exc) discard_next = 1'b1;
          else if (write_ok) exp_rf[op.rf_waddr] = xif_data;
        end
      endcase
      // A completed op that discards its successor was aborted
      if (discard_next) exp_abort++;
    end
  endtask

  ////////////////////////////////////////////////////////////////////
  // Trace player
  ////////////////////////////////////////////////////////////////////

  initial begin
    int          fd;
    int          waited;
    string       line;
    string       tag;
    logic [31:0] f1;
    logic [31:0] f2;
    logic [31:0] f3;
    logic [31:0] f4;
    logic [31:0] f5;
    ex_wb_pipe_t op;

    clk = 1'b0;
    rst_n_i = 1'b0;
    ex_valid_i = 1'b0;
    ex_op_i = '0;
    xif_result_valid_i = 1'b0;
    xif_result_i = '0;
    halt_req_i = 1'b0;
    rf_raddr_i = '0;
    discard_next = 1'b0;
    exp_done = 0;
    exp_abort = 0;
    xif_armed = 1'b0;
    xif_delay = 0;
    xif_data = '0;
    xif_exc = 1'b0;
    halt_cycles = 0;
    stall_seen = 1'b0;
    done_cnt = 0;
    abort_cnt = 0;
    last_kind = ALU;
    for (int i = 0; i < 32; i++) exp_rf[i] = '0;
    for (int i = 0; i < RAM_WORDS; i++) exp_mem[i] = '0;

    fd = $fopen("verif/wb_trace.txt", "r");
    if (fd == 0) begin
      $display("Could not open the trace file verif/wb_trace.txt");
      end_in_failure();
    end

    repeat (5) @(posedge clk);
    @(negedge clk);
    rst_n_i = 1'b1;

    while ($fgets(line, fd) != 0) begin
      if (line.len() < 2 || line.substr(0, 0) == "#") continue;
      f1 = '0;
      f2 = '0;
      f3 = '0;
      f4 = '0;
      f5 = '0;
      void'($sscanf(line, "%s %h %h %h %h %h", tag, f1, f2, f3, f4, f5));
      if (tag == "I") begin
        op             = '0;
        op.instr_valid = 1'b1;
        op.op_kind     = op_kind_e'(f1[1:0]);
        op.rf_waddr    = f2[4:0];
        op.rf_we       = f3[0];
        op.rf_wdata    = f4;
        op.mem_addr    = f5[7:0];
        model_op(op);
        issue_op(op);
      end else if (tag == "X") begin
        waited = 0;
        while (xif_armed) begin
          @(negedge clk);
          waited++;
          if (waited > TIMEOUT_CYCLES) report_timeout("previous XIF result never taken");
        end
        xif_delay = int'(f1);
        xif_data  = f2;
        xif_exc   = f3[0];
        xif_armed = 1'b1;
      end else if (tag == "H") begin
        halt_cycles = int'(f1);
      end else if (tag == "R") begin
        wait_idle();
        @(negedge clk);
        rf_raddr_i = f1[4:0];
        #1;
        check_value(exp_rf[f1[4:0]], f2, "reference model against trace");
        check_value(rf_rdata_o, exp_rf[f1[4:0]], "register read port");
        check_value(32'(done_cnt), 32'(exp_done), "ops completed on wb_valid_o");
        check_value(32'(abort_cnt), 32'(exp_abort), "ops aborted on abort_op_o");
      end else begin
        $display("Unknown command in trace line: %s", line);
        end_in_failure();
      end
    end
    $fclose(fd);

    check_value(32'(stall_seen), 32'd1, "data_stall_o seen during a load");

    $display("*** PASSED ***");
    $finish;
  end

  // Watchdog for the whole run
  initial begin
    #100000;
    report_timeout("simulation ran too long");
  end

endmodule

`default_nettype wire

/* verif/wb_trace.txt */
# I kind rd we data addr | X delay data exc | H cycles | R reg expected, all hex
# kind 0 ALU, 1 LOAD, 2 STORE, 3 XIF
I 0 01 1 00000011 00
I 0 02 1 00000022 00
I 0 00 1 deadbeef 00
R 01 00000011
R 02 00000022
R 00 00000000
I 2 00 0 a5a5f00d 10
I 1 03 1 00000000 10
R 03 a5a5f00d
I 1 04 1 00000000 c8
I 0 05 1 00000055 00
I 0 06 1 00000066 00
R 04 00000000
R 05 00000000
R 06 00000066
X 3 cafe0007 0
I 3 07 1 00000000 00
R 07 cafe0007
X 2 0badc0de 1
I 3 08 1 00000000 00
I 0 09 1 00000099 00
I 0 0a 1 000000aa 00
R 08 00000000
R 09 00000000
R 0a 000000aa
H 6
I 0 0b 1 000000bb 00
I 0 0c 1 000000cc 00
R 0b 000000bb
R 0c 000000cc
